// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define XLEN     32
`define NUM_REGS 32
`define PC_STEP  32'd4         // Next sequential instruction
`define RESET_PC 32'h0000_0000

// Major opcodes
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_REG_IMM  7'b0010011
`define OP_REG_REG  7'b0110011
`define OP_MISC_MEM 7'b0001111
`define OP_SYSTEM   7'b1110011

// ALU funct3
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101 // SRL or SRA
`define F3_OR   3'b110
`define F3_AND  3'b111

// Branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F7_ALT 7'b0100000 // SUB, SRA, SRAI

`endif

// ==== src/rv_pkg.sv ====
package rv_pkg;

  // Register or data word
  typedef logic [31:0] word_t;

  // Instruction address
  typedef logic [31:0] addr_t;

  // Raw instruction word
  typedef logic [31:0] insn_t;

  // Architectural register index, x0 to x31
  typedef logic [4:0] reg_idx_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

endpackage

// ==== src/rv_decoder.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_decoder (
  input  rv_pkg::insn_t    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::funct3_t  funct3,
  output logic             alt,
  output rv_pkg::word_t    imm,
  output logic             use_imm,
  output logic             is_lui,
  output logic             is_auipc,
  output logic             is_jal,
  output logic             is_jalr,
  output logic             is_branch,
  output logic             reg_write,
  output logic             halt,
  output logic             illegal
);

  rv_pkg::opcode_t opcode;
  rv_pkg::funct7_t funct7;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_j;
  rv_pkg::word_t   imm_u;
  logic            is_reg_reg;

  // Field split, same positions for every format
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // Immediates, sign bit is always insn[31]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0}; // Low 12 bits zero

  assign is_lui     = (opcode == `OP_LUI);
  assign is_auipc   = (opcode == `OP_AUIPC);
  assign is_jal     = (opcode == `OP_JAL);
  assign is_jalr    = (opcode == `OP_JALR);
  assign is_branch  = (opcode == `OP_BRANCH);
  assign is_reg_reg = (opcode == `OP_REG_REG);
  assign use_imm    = (opcode == `OP_REG_IMM); // ALU takes imm as operand b

  // SUB and SRA; SRAI is picked from imm[10] in the execute unit
  assign alt = is_reg_reg && (funct7 == `F7_ALT);

  always_comb begin
    case (opcode)
      `OP_LUI, `OP_AUIPC:    imm = imm_u;
      `OP_JAL:               imm = imm_j;
      `OP_BRANCH:            imm = imm_b;
      default:               imm = imm_i; // JALR and register-immediate group
    endcase
  end

  // Writes to x0 are dropped here
  assign reg_write = (is_lui || is_auipc || is_jal || is_jalr || use_imm || is_reg_reg)
                     && (rd != 5'd0);

  always_comb begin
    halt    = 1'b0;
    illegal = 1'b0;
    case (opcode)
      `OP_LUI, `OP_AUIPC, `OP_JAL: begin
        illegal = 1'b0;
      end
      `OP_JALR: begin
        illegal = (funct3 != 3'b000);
      end
      `OP_BRANCH: begin
        illegal = !(funct3 inside {`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU});
      end
      `OP_REG_IMM: begin
        // Shift immediates carry funct7 in the upper imm bits
        if (funct3 == `F3_SLL) begin
          illegal = (funct7 != 7'b0);
        end else if (funct3 == `F3_SR) begin
          illegal = (funct7 != 7'b0) && (funct7 != `F7_ALT);
        end
      end
      `OP_REG_REG: begin
        // M extension and other funct7 values land here
        if (funct7 == `F7_ALT) begin
          illegal = (funct3 != `F3_ADD) && (funct3 != `F3_SR);
        end else begin
          illegal = (funct7 != 7'b0);
        end
      end
      `OP_MISC_MEM: begin
        illegal = (funct3 != 3'b000); // Plain FENCE only, runs as a NOP
      end
      `OP_SYSTEM: begin
        halt    = (insn[31:7] == 25'b0); // ECALL
        illegal = !halt;                 // EBREAK, CSR access
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t wr_idx,
  input  logic             wr_en,
  input  rv_pkg::word_t    wr_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:`NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != 5'd0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Combinational reads, old value until the edge
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== src/rv_exec.sv ====
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_exec (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::funct3_t funct3,
  input  logic            alt,
  input  logic            use_imm,
  input  logic            is_lui,
  input  logic            is_auipc,
  input  logic            is_jal,
  input  logic            is_jalr,
  input  logic            is_branch,
  input  logic            reg_write,
  input  logic            illegal,
  output rv_pkg::addr_t   pc,
  output logic            wr_en,
  output rv_pkg::word_t   wr_data
);

  rv_pkg::word_t            op_b;
  rv_pkg::word_t            alu_result;
  logic [$clog2(`XLEN)-1:0] shamt;
  logic                     arith_shift;
  logic                     cond;
  logic                     taken;
  rv_pkg::word_t            jalr_sum;
  rv_pkg::addr_t            pc_plus_step;
  rv_pkg::addr_t            pc_plus_imm;
  rv_pkg::addr_t            next_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[$clog2(`XLEN)-1:0];

  // SRAI is marked by imm[10], SRA by funct7 through alt
  assign arith_shift = use_imm ? imm[10] : alt;

  always_comb begin
    alu_result = rs1_data + op_b;
    case (funct3)
      `F3_ADD: begin
        if (alt) begin
          alu_result = rs1_data - op_b;
        end else begin
          alu_result = rs1_data + op_b;
        end
      end
      `F3_SLL:  alu_result = rs1_data << shamt;
      `F3_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      `F3_SLTU: alu_result = {{(`XLEN-1){1'b0}}, rs1_data < op_b};
      `F3_XOR:  alu_result = rs1_data ^ op_b;
      `F3_SR: begin
        // SRA and SRAI fill with the sign bit
        if (arith_shift) begin
          alu_result = $signed(rs1_data) >>> shamt;
        end else begin
          alu_result = rs1_data >> shamt;
        end
      end
      `F3_OR:   alu_result = rs1_data | op_b;
      `F3_AND:  alu_result = rs1_data & op_b;
      default:  alu_result = rs1_data + op_b;
    endcase
  end

  // Branch condition, always on rs2 and never on the immediate
  always_comb begin
    case (funct3)
      `F3_BEQ:  cond = (rs1_data == rs2_data);
      `F3_BNE:  cond = (rs1_data != rs2_data);
      `F3_BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      `F3_BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      `F3_BLTU: cond = (rs1_data < rs2_data);
      `F3_BGEU: cond = (rs1_data >= rs2_data);
      default:  cond = 1'b0;
    endcase
  end

  assign taken = is_branch && cond;

  assign pc_plus_step = pc + `PC_STEP;
  assign pc_plus_imm  = pc + imm;      // Branch, JAL and AUIPC share this add
  assign jalr_sum     = rs1_data + imm;

  always_comb begin
    if (illegal) begin
      next_pc = pc_plus_step;          // Skip over it
    end else if (is_jalr) begin
      next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
    end else if (taken || is_jal) begin
      next_pc = pc_plus_imm;
    end else begin
      next_pc = pc_plus_step;
    end
  end

  always_comb begin
    if (is_lui) begin
      wr_data = imm;
    end else if (is_auipc) begin
      wr_data = pc_plus_imm;
    end else if (is_jal || is_jalr) begin
      wr_data = pc_plus_step;          // Link address
    end else begin
      wr_data = alu_result;
    end
  end

  assign wr_en = reg_write && !illegal;

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::insn_t    insn,
  output rv_pkg::addr_t    pc,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data,
  output logic             halt,
  output logic             illegal
);

  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::funct3_t  funct3;
  rv_pkg::word_t    imm;
  logic             alt;
  logic             use_imm;
  logic             is_lui;
  logic             is_auipc;
  logic             is_jal;
  logic             is_jalr;
  logic             is_branch;
  logic             reg_write;

  rv_decoder i_decoder (
    .insn      (insn),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (wb_rd),      // Also the retirement index
    .funct3    (funct3),
    .alt       (alt),
    .imm       (imm),
    .use_imm   (use_imm),
    .is_lui    (is_lui),
    .is_auipc  (is_auipc),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_branch (is_branch),
    .reg_write (reg_write),
    .halt      (halt),
    .illegal   (illegal)
  );

  // Write port closes the loop from the execute unit
  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .wr_idx   (wb_rd),
    .wr_en    (wb_en),
    .wr_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_exec i_exec (
    .clk       (clk),
    .rst       (rst),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .funct3    (funct3),
    .alt       (alt),
    .use_imm   (use_imm),
    .is_lui    (is_lui),
    .is_auipc  (is_auipc),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_branch (is_branch),
    .reg_write (reg_write),
    .illegal   (illegal),
    .pc        (pc),
    .wr_en     (wb_en),
    .wr_data   (wb_data)
  );

endmodule

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_VECS     = 43;  // Steps in the vector file
  localparam int FIELDS       = 7;   // Words per step
  localparam int VEC_WORDS    = 512;

  // Word offsets within one step
  localparam int F_INSN    = 0;
  localparam int F_PC      = 1;
  localparam int F_WB_EN   = 2;
  localparam int F_WB_RD   = 3;
  localparam int F_WB_DATA = 4;
  localparam int F_HALT    = 5;
  localparam int F_ILLEGAL = 6;

  localparam logic [31:0] NOP = 32'h0000_0013; // ADDI x0, x0, 0

  logic             clk;
  logic             rst;
  rv_pkg::insn_t    insn;
  rv_pkg::addr_t    pc;
  logic             wb_en;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::word_t    wb_data;
  logic             halt;
  logic             illegal;

  logic [31:0] vec_mem [0:VEC_WORDS-1];

  rv_core i_rv_core (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .halt    (halt),
    .illegal (illegal)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Marks words the file did not overwrite
  function automatic logic [31:0] fill_word(int addr);
    return 32'hbad0_0000 | 32'(addr);
  endfunction

  function automatic logic [31:0] vec_field(int step, int field);
    logic [8:0] idx;
    idx = 9'(step * FIELDS + field);
    return vec_mem[idx];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected %08h actual %08h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic load_vectors();
    for (int a = 0; a < VEC_WORDS; a++) begin
      vec_mem[9'(a)] = fill_word(a);
    end
    $readmemh("tb/rv_core_vectors.txt", vec_mem);
    // Last step must be loaded and nothing may follow it
    if ((vec_field(NUM_VECS - 1, F_ILLEGAL) == fill_word((NUM_VECS - 1) * FIELDS + F_ILLEGAL))
        || (vec_field(NUM_VECS, F_INSN) != fill_word(NUM_VECS * FIELDS))) begin
      $display("The vector file tb/rv_core_vectors.txt is missing or has the wrong length");
      $display("TEST RESULT: FAIL");
      $fatal(1, "Bad vector file");
    end
  endtask

  // Present one instruction and check the ports just before the edge
  task automatic run_step(input int step);
    logic [31:0] exp_en;
    exp_en = vec_field(step, F_WB_EN);
    insn = vec_field(step, F_INSN);
    #(CLK_PERIOD / 2 - 1);
    check_value($sformatf("step %0d pc", step), vec_field(step, F_PC), pc);
    check_value($sformatf("step %0d wb_en", step), exp_en, {31'b0, wb_en});
    check_value($sformatf("step %0d halt", step), vec_field(step, F_HALT), {31'b0, halt});
    check_value($sformatf("step %0d illegal", step), vec_field(step, F_ILLEGAL),
                {31'b0, illegal});
    if (exp_en != 32'd0) begin  // Index and data only mean something with a write
      check_value($sformatf("step %0d wb_rd", step), vec_field(step, F_WB_RD),
                  {27'b0, wb_rd});
      check_value($sformatf("step %0d wb_data", step), vec_field(step, F_WB_DATA), wb_data);
    end
  endtask

  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    insn = NOP;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int s = 0; s < NUM_VECS; s++) begin
      run_step(s);
      @(negedge clk);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #((NUM_VECS + RESET_CYCLES + 10) * CLK_PERIOD);
    $display("Timeout: the vector run did not finish within %0d ns",
             (NUM_VECS + RESET_CYCLES + 10) * CLK_PERIOD);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== filelist.f ====
+incdir+include
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_exec.sv
src/rv_core.sv
tb/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_rv_core

# A failing run still leaves its log for the search below
./obj_dir/Vtb_rv_core > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "TEST RESULT: PASS" "$LOG"; then
  exit 0
else
  exit 1
fi

// ==== tb/rv_core_vectors.txt ====
// insn     pc       wb_en wb_rd wb_data  halt illegal
// wb_rd and wb_data are only checked when wb_en is 1
00000013 00000000 0 00 00000000 0 0
800000b7 00000004 1 01 80000000 0 0
00001117 00000008 1 02 00001008 0 0
ffb00193 0000000c 1 03 fffffffb 0 0
00700213 00000010 1 04 00000007 0 0
ffc1a293 00000014 1 05 00000001 0 0
0071b313 00000018 1 06 00000000 0 0
0f01c393 0000001c 1 07 ffffff0b 0 0
10026413 00000020 1 08 00000107 0 0
7ff1f493 00000024 1 09 000007fb 0 0
00421513 00000028 1 0a 00000070 0 0
0040d593 0000002c 1 0b 08000000 0 0
4040d613 00000030 1 0c f8000000 0 0
004186b3 00000034 1 0d 00000002 0 0
40418733 00000038 1 0e fffffff4 0 0
004217b3 0000003c 1 0f 00000380 0 0
0041a833 00000040 1 10 00000001 0 0
0041b8b3 00000044 1 11 00000000 0 0
0041c933 00000048 1 12 fffffffc 0 0
0040d9b3 0000004c 1 13 01000000 0 0
4040da33 00000050 1 14 ff000000 0 0
00456ab3 00000054 1 15 00000077 0 0
00a1fb33 00000058 1 16 00000070 0 0
00520013 0000005c 0 00 00000000 0 0
00400bb3 00000060 1 17 00000007 0 0
01720463 00000064 0 00 00000000 0 0
00418463 0000006c 0 00 00000000 0 0
00419463 00000070 0 00 00000000 0 0
01721463 00000078 0 00 00000000 0 0
0041c463 0000007c 0 00 00000000 0 0
00324463 00000084 0 00 00000000 0 0
fe3258e3 00000088 0 00 00000000 0 0
0041d463 00000078 0 00 00000000 0 0
00326463 0000007c 0 00 00000000 0 0
0041e463 00000084 0 00 00000000 0 0
0041f463 00000088 0 00 00000000 0 0
00327463 00000090 0 00 00000000 0 0
02000c6f 00000094 1 18 00000098 0 0
011c0ce7 000000b4 1 19 000000b8 0 0
00002d03 000000a8 0 00 00000000 0 1
0ff0000f 000000ac 0 00 00000000 0 0
02420db3 000000b0 0 00 00000000 0 1
00000073 000000b4 0 00 00000000 1 0
